/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
LINT     = --lint-only --timing
TOP      = mixed_width_ram_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = sim failed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/mixed_width_ram_tb.sv */
// mixed width ram testbench
`timescale 1ns/1ps

module mixed_width_ram_tb;

	// upper bound for any single wait
	localparam int TIMEOUT_CYCLES = 20;

	logic clk_a;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	ram_pkg::word_addr_t paddr;
	ram_pkg::word_t pwdata;
	ram_pkg::word_t prdata;
	logic pready;
	logic byte_rd_en;
	ram_pkg::byte_addr_t byte_addr;
	ram_pkg::byte_t byte_data;
	logic byte_valid;

	// reference copy of every word written over apb
	ram_pkg::word_t model [1 << ram_pkg::WORD_ADDR_WIDTH];
	logic [31:0] rng_state;
	int error_count;
	int errors_at_start;
	int test_count;
	int failed_tests;

	mixed_width_ram DUT (.*);

	// 4 ns period
	always #2 clk_a = ~clk_a;

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// lane 0 is the top byte, lane 3 the bottom one
	function automatic ram_pkg::byte_t lane_byte(input ram_pkg::word_t word, input int lane);
		return ram_pkg::byte_t'(word >> (8 * (3 - lane)));
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count != errors_at_start) begin
			failed_tests++;
		end
		$display("test %s done with %0d errors", name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	// one apb transfer, entered and left just after a falling edge
	task automatic apb_transfer(input logic write, input ram_pkg::word_addr_t addr,
		input ram_pkg::word_t data, output ram_pkg::word_t rdata, output int cycles);
		int waited;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk_a);
		// access phase, setup cycle already counted
		penable = 1'b1;
		cycles = 2;
		waited = 0;
		while (!pready && waited < TIMEOUT_CYCLES) begin
			@(negedge clk_a);
			cycles++;
			waited++;
		end
		assert (pready) else begin
			$display("no pready within %0d cycles on apb access to %h", TIMEOUT_CYCLES, addr);
			error_count++;
		end
		rdata = prdata;
		@(negedge clk_a);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// write completes in the first access cycle
	task automatic apb_write(input ram_pkg::word_addr_t addr, input ram_pkg::word_t data);
		ram_pkg::word_t rdata;
		int cycles;
		apb_transfer(1'b1, addr, data, rdata, cycles);
		check_value("write pready cycle", 2, cycles);
		model[addr] = data;
	endtask

	task automatic apb_read_check(input ram_pkg::word_addr_t addr);
		ram_pkg::word_t rdata;
		int cycles;
		apb_transfer(1'b0, addr, '0, rdata, cycles);
		check_value("read pready cycle", ram_pkg::WORD_READ_LATENCY + 1, cycles);
		check_value("prdata", model[addr], rdata);
	endtask

	// single byte read, latency counted in cycles after byte_rd_en
	task automatic byte_read(input ram_pkg::byte_addr_t addr, output ram_pkg::byte_t data,
		output int latency);
		byte_rd_en = 1'b1;
		byte_addr = addr;
		@(negedge clk_a);
		byte_rd_en = 1'b0;
		latency = 1;
		while (!byte_valid && latency < TIMEOUT_CYCLES) begin
			@(negedge clk_a);
			latency++;
		end
		assert (byte_valid) else begin
			$display("no byte_valid within %0d cycles for byte address %h", TIMEOUT_CYCLES, addr);
			error_count++;
		end
		data = byte_data;
	endtask

	task automatic byte_read_check(input ram_pkg::word_addr_t addr, input int lane,
		input ram_pkg::byte_t expected);
		ram_pkg::byte_t data;
		int latency;
		byte_read({addr, ram_pkg::lane_t'(lane)}, data, latency);
		check_value("byte_valid latency", ram_pkg::BYTE_READ_LATENCY, latency);
		check_value("byte_data", 32'(expected), 32'(data));
	endtask

	task automatic test_reset();
		reset = 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_a);
			check_value("pready", 0, 32'(pready));
			check_value("byte_valid", 0, 32'(byte_valid));
		end
		reset = 1'b0;
		// outputs stay quiet once reset is released
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_a);
			check_value("pready", 0, 32'(pready));
			check_value("byte_valid", 0, 32'(byte_valid));
		end
		end_test("reset");
	endtask

	task automatic test_word_round_trip();
		apb_write(12'h123, 32'ha5c3_0f96);
		apb_read_check(12'h123);
		end_test("word round trip");
	endtask

	task automatic test_byte_lanes();
		apb_write(12'h2a5, 32'h1122_3344);
		for (int lane = 0; lane < ram_pkg::LANE_COUNT; lane++) begin
			byte_read_check(12'h2a5, lane, lane_byte(model[12'h2a5], lane));
		end
		end_test("byte lanes");
	endtask

	task automatic test_streamed_bytes();
		ram_pkg::word_addr_t addrs [4];
		int seen_cycle [$];
		ram_pkg::byte_t seen_data [$];
		ram_pkg::byte_t expected [$];
		int n;
		int lane;
		n = 12;
		// banks 0, 1, 3 and 7
		addrs = '{12'h0c0, 12'h3ff, 12'h600, 12'hf01};
		foreach (addrs[i]) begin
			apb_write(addrs[i], xorshift32());
		end
		// sample outputs first, then drive the next read
		for (int c = 0; c < n + ram_pkg::BYTE_READ_LATENCY + 3; c++) begin
			if (byte_valid) begin
				seen_cycle.push_back(c);
				seen_data.push_back(byte_data);
			end
			byte_rd_en = (c < n);
			if (c < n) begin
				lane = (c + c / 4) % 4;
				byte_addr = {addrs[c % 4], ram_pkg::lane_t'(lane)};
				expected.push_back(lane_byte(model[addrs[c % 4]], lane));
			end
			@(negedge clk_a);
		end
		check_value("streamed byte count", n, seen_data.size());
		for (int i = 0; i < n && i < seen_data.size(); i++) begin
			check_value("byte_valid cycle", i + ram_pkg::BYTE_READ_LATENCY, seen_cycle[i]);
			check_value("byte_data", 32'(expected[i]), 32'(seen_data[i]));
		end
		end_test("streamed bytes");
	endtask

	task automatic test_bank_coverage();
		ram_pkg::word_addr_t addrs [$];
		ram_pkg::bank_sel_t bank;
		// bottom, top and one random word of every bank
		for (int b = 0; b < ram_pkg::BANK_COUNT; b++) begin
			bank = ram_pkg::bank_sel_t'(b);
			addrs.push_back({bank, ram_pkg::bank_addr_t'(0)});
			addrs.push_back({bank, ram_pkg::bank_addr_t'(ram_pkg::BANK_DEPTH - 1)});
			addrs.push_back({bank, ram_pkg::bank_addr_t'(xorshift32())});
		end
		foreach (addrs[i]) begin
			apb_write(addrs[i], xorshift32());
		end
		foreach (addrs[i]) begin
			apb_read_check(addrs[i]);
			for (int lane = 0; lane < ram_pkg::LANE_COUNT; lane++) begin
				byte_read_check(addrs[i], lane, lane_byte(model[addrs[i]], lane));
			end
		end
		end_test("bank coverage");
	endtask

	task automatic test_read_first();
		ram_pkg::word_t old_word;
		ram_pkg::word_t new_word;
		ram_pkg::byte_t data;
		int latency;
		old_word = xorshift32();
		new_word = ~old_word;
		apb_write(12'h9e7, old_word);
		// write setup and byte read hit the same edge
		fork
			apb_write(12'h9e7, new_word);
			byte_read({12'h9e7, 2'd2}, data, latency);
		join
		check_value("byte_valid latency", ram_pkg::BYTE_READ_LATENCY, latency);
		check_value("byte_data", 32'(lane_byte(old_word, 2)), 32'(data));
		byte_read_check(12'h9e7, 2, lane_byte(new_word, 2));
		end_test("read first collision");
	endtask

	initial begin
		clk_a = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		byte_rd_en = 1'b0;
		byte_addr = '0;
		rng_state = 32'd57664;
		error_count = 0;
		errors_at_start = 0;
		test_count = 0;
		failed_tests = 0;
		test_reset();
		test_word_round_trip();
		test_byte_lanes();
		test_streamed_bytes();
		test_bank_coverage();
		test_read_first();
		$display("tests %0d, tests with errors %0d, errors %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
source/ram_pkg.sv
source/ram_port_if.sv
source/apb_word_port.sv
source/banked_word_ram.sv
source/byte_read_port.sv
source/mixed_width_ram.sv
dv/mixed_width_ram_tb.sv

/* source/apb_word_port.sv */
// apb word port
`timescale 1ns/1ps

module apb_word_port (
	input logic clk_a,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input ram_pkg::word_addr_t paddr,
	input ram_pkg::word_t pwdata,
	output ram_pkg::word_t prdata,
	output logic pready,
	word_req_if.initiator req
);

	// idle or waiting on read data
	typedef enum logic {
		st_idle,
		st_read_wait
	} state_t;

	state_t state;
	logic setup;
	logic write_ack;
	ram_pkg::word_t rdata_hold;

	// setup phase of a new transfer, only taken when idle
	assign setup = psel && !penable && (state == st_idle);

	// request goes out on the setup cycle itself
	assign req.req = setup;
	assign req.we = pwrite;
	assign req.addr = paddr;
	assign req.wdata = pwdata;

	always_ff @(posedge clk_a) begin
		if (reset) begin
			state <= st_idle;
			write_ack <= 1'b0;
		end else begin
			// write lands at the end of setup, ack in first access cycle
			write_ack <= setup && pwrite;
			case (state)
				st_idle: begin
					if (setup && !pwrite) begin
						state <= st_read_wait;
					end
				end
				st_read_wait: begin
					// access phase ends with the read data
					if (req.rvalid) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// keep the last read word on prdata between transfers
	always_ff @(posedge clk_a) begin
		if (req.rvalid) begin
			rdata_hold <= req.rdata;
		end
	end

	// rdata is already registered in the ram, pass it straight on rvalid
	assign prdata = req.rvalid ? req.rdata : rdata_hold;
	assign pready = write_ack || ((state == st_read_wait) && req.rvalid);

	// apb protocol, access phase only inside a selected transfer
	penable_needs_psel: assert property (@(posedge clk_a) disable iff (reset)
		penable |-> psel);

	// ram returns read data only for a read this port is waiting on
	rvalid_only_when_waiting: assert property (@(posedge clk_a) disable iff (reset)
		req.rvalid |-> (state == st_read_wait));

endmodule

/* source/banked_word_ram.sv */
// banked word ram
`timescale 1ns/1ps

module banked_word_ram (
	input logic clk_a,
	input logic reset,
	word_req_if.target req,
	word_read_if.target rd
);

	// bank select and in-bank address for each port
	ram_pkg::bank_sel_t req_sel;
	ram_pkg::bank_addr_t req_bank_addr;
	ram_pkg::bank_sel_t rd_sel;
	ram_pkg::bank_addr_t rd_bank_addr;

	// one-hot write enable, one bit per bank
	logic [ram_pkg::BANK_COUNT-1:0] bank_we;
	logic req_rd;

	// first stage holds one registered word per bank
	ram_pkg::word_t req_bank_q [ram_pkg::BANK_COUNT];
	ram_pkg::word_t rd_bank_q [ram_pkg::BANK_COUNT];
	ram_pkg::bank_sel_t req_sel_q;
	ram_pkg::bank_sel_t rd_sel_q;
	logic req_stage_v;
	logic rd_stage_v;

	// second stage holds the registered mux outputs
	ram_pkg::word_t req_word_q;
	ram_pkg::word_t rd_word_q;
	logic req_valid_q;
	logic rd_valid_q;

	// upper bits pick the bank
	assign req_sel = req.addr[ram_pkg::WORD_ADDR_WIDTH-1 -: ram_pkg::BANK_SEL_BITS];
	assign req_bank_addr = req.addr[ram_pkg::BANK_ADDR_WIDTH-1:0];
	assign rd_sel = rd.addr[ram_pkg::WORD_ADDR_WIDTH-1 -: ram_pkg::BANK_SEL_BITS];
	assign rd_bank_addr = rd.addr[ram_pkg::BANK_ADDR_WIDTH-1:0];

	// apb reads use the same request pulse with we low
	assign req_rd = req.req && !req.we;

	// write enable only reaches the selected bank
	always_comb begin
		bank_we = '0;
		if (req.req && req.we) begin
			bank_we[req_sel] = 1'b1;
		end
	end

	for (genvar b = 0; b < ram_pkg::BANK_COUNT; b++) begin : g_bank
		ram_pkg::word_t mem [ram_pkg::BANK_DEPTH];

		// reads see the old contents on a same-cycle write
		always_ff @(posedge clk_a) begin
			if (bank_we[b]) begin
				mem[req_bank_addr] <= req.wdata;
			end
			if (req_rd) begin
				req_bank_q[b] <= mem[req_bank_addr];
			end
			if (rd.rd_en) begin
				rd_bank_q[b] <= mem[rd_bank_addr];
			end
		end
	end

	// bank select follows the bank read by one cycle into the mux
	always_ff @(posedge clk_a) begin
		if (req_rd) begin
			req_sel_q <= req_sel;
		end
		if (rd.rd_en) begin
			rd_sel_q <= rd_sel;
		end
		if (req_stage_v) begin
			req_word_q <= req_bank_q[req_sel_q];
		end
		if (rd_stage_v) begin
			rd_word_q <= rd_bank_q[rd_sel_q];
		end
	end

	// valid bits shift in step with the data
	always_ff @(posedge clk_a) begin
		if (reset) begin
			req_stage_v <= 1'b0;
			req_valid_q <= 1'b0;
			rd_stage_v <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			req_stage_v <= req_rd;
			req_valid_q <= req_stage_v;
			rd_stage_v <= rd.rd_en;
			rd_valid_q <= rd_stage_v;
		end
	end

	assign req.rdata = req_word_q;
	assign req.rvalid = req_valid_q;
	assign rd.word = rd_word_q;
	assign rd.valid = rd_valid_q;

	// each apb request arrives as a single-cycle pulse
	req_one_cycle: assert property (@(posedge clk_a) disable iff (reset)
		req.req |=> !req.req);

endmodule

/* source/byte_read_port.sv */
// byte read port
`timescale 1ns/1ps

module byte_read_port (
	input logic clk_a,
	input logic reset,
	input logic byte_rd_en,
	input ram_pkg::byte_addr_t byte_addr,
	output ram_pkg::byte_t byte_data,
	output logic byte_valid,
	word_read_if.initiator rd
);

	// lane bits travel alongside the word read
	ram_pkg::lane_t lane_pipe [ram_pkg::WORD_READ_LATENCY];
	// one bit per word read in flight
	logic [ram_pkg::WORD_READ_LATENCY-1:0] pending;
	ram_pkg::lane_t lane_now;

	// word part of the byte address goes straight to the ram
	assign rd.rd_en = byte_rd_en;
	assign rd.addr = byte_addr[ram_pkg::BYTE_ADDR_WIDTH-1:ram_pkg::LANE_BITS];

	// lane pipeline, shifted every cycle
	always_ff @(posedge clk_a) begin
		lane_pipe[0] <= byte_addr[ram_pkg::LANE_BITS-1:0];
		for (int i = 1; i < ram_pkg::WORD_READ_LATENCY; i++) begin
			lane_pipe[i] <= lane_pipe[i-1];
		end
	end

	// tracks which pipeline slots hold a real read
	always_ff @(posedge clk_a) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= {pending[ram_pkg::WORD_READ_LATENCY-2:0], byte_rd_en};
		end
	end

	// lane that belongs to the word arriving now
	assign lane_now = lane_pipe[ram_pkg::WORD_READ_LATENCY-1];

	// lane 0 is bits 31:24, msb first
	always_ff @(posedge clk_a) begin
		if (rd.valid) begin
			byte_data <= rd.word[(ram_pkg::LANE_COUNT - 1 - int'(lane_now))
				* ram_pkg::BYTE_WIDTH +: ram_pkg::BYTE_WIDTH];
		end
	end

	// one byte out per word back, no back-pressure
	always_ff @(posedge clk_a) begin
		if (reset) begin
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= rd.valid;
		end
	end

	// every word returned by the ram matches a lane entry in flight
	valid_has_lane: assert property (@(posedge clk_a) disable iff (reset)
		rd.valid |-> pending[ram_pkg::WORD_READ_LATENCY-1]);

endmodule

/* source/mixed_width_ram.sv */
// mixed width ram top
`timescale 1ns/1ps

module mixed_width_ram (
	input logic clk_a,
	input logic reset,
	// apb word port
	input logic psel,
	input logic penable,
	input logic pwrite,
	input ram_pkg::word_addr_t paddr,
	input ram_pkg::word_t pwdata,
	output ram_pkg::word_t prdata,
	output logic pready,
	// pipelined byte read port
	input logic byte_rd_en,
	input ram_pkg::byte_addr_t byte_addr,
	output ram_pkg::byte_t byte_data,
	output logic byte_valid
);

	// apb side to ram
	word_req_if req_if ();
	// byte side to ram
	word_read_if rd_if ();

	// apb transfers become word requests
	apb_word_port u_apb_port (
		.clk_a(clk_a),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.req(req_if.initiator)
	);

	// eight banks, one write path and two read paths
	banked_word_ram u_ram (
		.clk_a(clk_a),
		.reset(reset),
		.req(req_if.target),
		.rd(rd_if.target)
	);

	// byte reads as word reads plus lane select
	byte_read_port u_byte_port (
		.clk_a(clk_a),
		.reset(reset),
		.byte_rd_en(byte_rd_en),
		.byte_addr(byte_addr),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.rd(rd_if.initiator)
	);

endmodule

/* source/ram_pkg.sv */
// mixed width ram definitions
package ram_pkg;

	// data widths
	localparam int WORD_WIDTH = 32;
	localparam int BYTE_WIDTH = 8;

	// byte lanes per word, lane 0 is the most significant byte
	localparam int LANE_COUNT = WORD_WIDTH / BYTE_WIDTH;
	localparam int LANE_BITS = $clog2(LANE_COUNT);

	// banking, upper word address bits pick the bank
	localparam int BANK_COUNT = 8;
	localparam int BANK_SEL_BITS = $clog2(BANK_COUNT);
	localparam int BANK_ADDR_WIDTH = 9;
	localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

	// address widths for the two ports
	localparam int WORD_ADDR_WIDTH = BANK_SEL_BITS + BANK_ADDR_WIDTH;
	localparam int BYTE_ADDR_WIDTH = WORD_ADDR_WIDTH + LANE_BITS;

	// bank read register plus mux output register
	localparam int WORD_READ_LATENCY = 2;
	// one more stage for the lane select
	localparam int BYTE_READ_LATENCY = WORD_READ_LATENCY + 1;

	// payload types
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [BYTE_WIDTH-1:0] byte_t;

	// address types
	typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
	typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;
	typedef logic [BANK_SEL_BITS-1:0] bank_sel_t;
	typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
	typedef logic [LANE_BITS-1:0] lane_t;

endpackage

/* source/ram_port_if.sv */
// word port interfaces
`timescale 1ns/1ps

// read/write word requests from the apb side
interface word_req_if;
	// one-cycle request pulse
	logic req;
	// write when high, read when low
	logic we;
	ram_pkg::word_addr_t addr;
	ram_pkg::word_t wdata;
	// read data, valid only with rvalid
	ram_pkg::word_t rdata;
	logic rvalid;

	// request side
	modport initiator (
		output req,
		output we,
		output addr,
		output wdata,
		input rdata,
		input rvalid
	);

	// memory side
	modport target (
		input req,
		input we,
		input addr,
		input wdata,
		output rdata,
		output rvalid
	);
endinterface

// pipelined word reads for the byte port
interface word_read_if;
	// may be high every cycle
	logic rd_en;
	ram_pkg::word_addr_t addr;
	ram_pkg::word_t word;
	// pulses WORD_READ_LATENCY cycles after rd_en
	logic valid;

	// read requester
	modport initiator (
		output rd_en,
		output addr,
		input word,
		input valid
	);

	// memory side
	modport target (
		input rd_en,
		input addr,
		output word,
		output valid
	);
endinterface
